/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_fm_accel
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

# static checks over RTL and testbench
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run, exit status follows the testbench
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+src
src/fmi_pkg.sv
src/wb_pkg.sv
src/wb_slave.sv
src/query_buffer.sv
src/backward_search.sv
src/search_result.sv
src/fm_accel_top.sv
test/tb_occ_mem.sv
test/tb_fm_accel.sv

/* src/backward_search.sv */
`timescale 1ns/1ns

module backward_search (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               start_i,
    input  fmi_pkg::ctab_t     ctab_i,
    input  fmi_pkg::idx_t      n_i,
    input  fmi_pkg::qlen_t     len_i,
    output fmi_pkg::qaddr_t    qry_raddr_o,
    input  fmi_pkg::sym_t      qry_sym_i,
    output logic               occ_req_valid_o,
    output fmi_pkg::occ_req_t  occ_req_o,
    input  logic               occ_rsp_valid_i,
    input  fmi_pkg::occ_rsp_t  occ_rsp_i,
    output logic               busy_o,
    output logic               fin_valid_o,
    output fmi_pkg::interval_t fin_o
);
    import fmi_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        REQ_LO,     // occ(sym, lo) outstanding
        REQ_HI,     // occ(sym, hi) outstanding
        UPDATE,     // fold both counts into the interval
        FINISH      // hand result over
    } state_t;

    state_t    state_q;
    qaddr_t    step_q;          // current query position
    interval_t iv_q;
    idx_t      cnt_lo_q;
    idx_t      cnt_hi_q;
    idx_t      c_sym;           // C[sym] of current base
    interval_t iv_nxt;
    logic      iv_empty;

    ////////////////////////////////////////
    // interval arithmetic
    assign c_sym = ctab_i[qry_sym_i];

    always_comb begin
        iv_nxt.lo = c_sym + cnt_lo_q;
        iv_nxt.hi = c_sym + cnt_hi_q;
    end

    assign iv_empty = iv_nxt.lo >= iv_nxt.hi;    // no match left

    ////////////////////////////////////////
    // control fsm
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        step_q  <= qaddr_t'(len_i - 1'b1);
                        state_q <= (len_i == '0) ? FINISH : REQ_LO;  // empty query
                    end
                end
                REQ_LO: begin
                    if (occ_rsp_valid_i) state_q <= REQ_HI;
                end
                REQ_HI: begin
                    if (occ_rsp_valid_i) state_q <= UPDATE;
                end
                UPDATE: begin
                    if (iv_empty || step_q == '0) begin
                        state_q <= FINISH;                   // early out or last base
                    end else begin
                        step_q  <= step_q - 1'b1;
                        state_q <= REQ_LO;
                    end
                end
                FINISH:  state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // datapath
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            iv_q.lo <= '0;                               // whole text
            iv_q.hi <= n_i;
        end
        if (state_q == REQ_LO && occ_rsp_valid_i) cnt_lo_q <= occ_rsp_i.cnt;
        if (state_q == REQ_HI && occ_rsp_valid_i) cnt_hi_q <= occ_rsp_i.cnt;
        if (state_q == UPDATE) iv_q <= iv_nxt;
    end

    // occ master side, one request in flight
    assign occ_req_valid_o = (state_q == REQ_LO) || (state_q == REQ_HI);

    always_comb begin
        occ_req_o.sym = qry_sym_i;
        occ_req_o.pos = (state_q == REQ_HI) ? iv_q.hi : iv_q.lo;
    end

    assign qry_raddr_o = step_q;
    assign busy_o      = state_q != IDLE;                // covers FINISH too
    assign fin_valid_o = state_q == FINISH;
    assign fin_o       = iv_q;

    ////////////////////////////////////////
    // request held until the memory answers
    property p_req_stable;
        @(posedge clk_i) disable iff (rst_i)
        occ_req_valid_o && !occ_rsp_valid_i |=> occ_req_valid_o && $stable(occ_req_o);
    endproperty
    a_req_stable: assert property (p_req_stable);

    // occ is monotonic in pos, so a live step never inverts the interval
    property p_iv_order;
        @(posedge clk_i) disable iff (rst_i)
        (state_q == UPDATE) && (iv_q.lo < iv_q.hi) |-> cnt_lo_q <= cnt_hi_q;
    endproperty
    a_iv_order: assert property (p_iv_order);

endmodule

/* src/fm_accel_top.sv */
`timescale 1ns/1ns

module fm_accel_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  wb_pkg::wb_req_t   wb_req_i,
    output wb_pkg::wb_rsp_t   wb_rsp_o,
    output logic              occ_req_valid_o,
    output fmi_pkg::occ_req_t occ_req_o,
    input  logic              occ_rsp_valid_i,
    input  fmi_pkg::occ_rsp_t occ_rsp_i,
    output logic              irq_o
);
    import fmi_pkg::*;

    // host side -> engine
    logic      start;
    ctab_t     ctab;
    idx_t      n;
    qlen_t     len;
    logic      qry_we;
    qaddr_t    qry_waddr;
    sym_t      qry_wsym;
    // engine <-> query store
    qaddr_t    qry_raddr;
    sym_t      qry_sym;
    // engine -> results
    logic      busy;
    logic      fin_valid;
    interval_t fin;
    interval_t res;
    idx_t      cnt;
    logic      done;

    ////////////////////////////////////////
    wb_slave u_wb_slave (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .busy_i      (busy),
        .res_i       (res),
        .cnt_i       (cnt),
        .done_i      (done),
        .start_o     (start),
        .ctab_o      (ctab),
        .n_o         (n),
        .len_o       (len),
        .qry_we_o    (qry_we),
        .qry_waddr_o (qry_waddr),
        .qry_wsym_o  (qry_wsym)
    );

    query_buffer u_query_buffer (
        .clk_i   (clk_i),
        .we_i    (qry_we),
        .waddr_i (qry_waddr),
        .wsym_i  (qry_wsym),
        .raddr_i (qry_raddr),
        .rsym_o  (qry_sym)
    );

    backward_search u_backward_search (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .start_i         (start),
        .ctab_i          (ctab),
        .n_i             (n),
        .len_i           (len),
        .qry_raddr_o     (qry_raddr),
        .qry_sym_i       (qry_sym),
        .occ_req_valid_o (occ_req_valid_o),
        .occ_req_o       (occ_req_o),
        .occ_rsp_valid_i (occ_rsp_valid_i),
        .occ_rsp_i       (occ_rsp_i),
        .busy_o          (busy),
        .fin_valid_o     (fin_valid),
        .fin_o           (fin)
    );

    search_result u_search_result (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start),
        .fin_valid_i (fin_valid),
        .fin_i       (fin),
        .res_o       (res),
        .cnt_o       (cnt),
        .done_o      (done),
        .irq_o       (irq_o)
    );

endmodule

/* src/fmi_pkg.sv */
`include "fmi_settings.svh"

package fmi_pkg;

    ////////////////////////////////////////
    // query geometry
    localparam int QRY_MAX = `FMI_QRY_MAX;
    localparam int QRY_AW  = $clog2(QRY_MAX);     // 5 bits for 32 symbols

    typedef logic [QRY_AW-1:0] qaddr_t;           // symbol slot
    typedef logic [QRY_AW:0]   qlen_t;            // length, 0..QRY_MAX

    ////////////////////////////////////////
    // index domain
    typedef logic [1:0] sym_t;                    // A=0 C=1 G=2 T=3
    typedef logic [`FMI_IDX_W-1:0] idx_t;

    // half-open suffix-array range [lo, hi)
    typedef struct packed {
        idx_t lo;
        idx_t hi;
    } interval_t;

    // C table, one entry per base
    typedef idx_t [3:0] ctab_t;

    // occ(sym, pos), count of sym in bwt[0 .. pos-1]
    typedef struct packed {
        sym_t sym;
        idx_t pos;
    } occ_req_t;

    typedef struct packed {
        idx_t cnt;
    } occ_rsp_t;

endpackage

/* src/fmi_settings.svh */
`ifndef FMI_SETTINGS_SVH
`define FMI_SETTINGS_SVH

// suffix-array index and count width, also bounds N
`define FMI_IDX_W 16

// longest query in symbols
`define FMI_QRY_MAX 32

// wishbone byte address
`define WB_ADDR_W 8

`endif

/* src/query_buffer.sv */
`timescale 1ns/1ns
`include "fmi_settings.svh"

module query_buffer (
    input  logic            clk_i,
    input  logic            we_i,
    input  fmi_pkg::qaddr_t waddr_i,
    input  fmi_pkg::sym_t   wsym_i,
    input  fmi_pkg::qaddr_t raddr_i,
    output fmi_pkg::sym_t   rsym_o
);
    import fmi_pkg::*;

    // one base per slot, slot i = query position i
    sym_t mem_q [`FMI_QRY_MAX];

    ////////////////////////////////////////
    // host write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wsym_i;       // load while idle
        end
    end

    ////////////////////////////////////////
    // search read port
    // engine walks raddr from len-1 down to 0,
    // so bases leave last-first as backward search needs
    assign rsym_o = mem_q[raddr_i];         // async, same-cycle

endmodule

/* src/search_result.sv */
`timescale 1ns/1ns

module search_result (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               start_i,
    input  logic               fin_valid_i,
    input  fmi_pkg::interval_t fin_i,
    output fmi_pkg::interval_t res_o,
    output fmi_pkg::idx_t      cnt_o,
    output logic               done_o,
    output logic               irq_o
);
    import fmi_pkg::*;

    interval_t res_q;
    idx_t      cnt_q;
    idx_t      cnt_nxt;
    logic      done_q;

    // hit count, empty range gives zero
    assign cnt_nxt = (fin_i.lo < fin_i.hi) ? idx_t'(fin_i.hi - fin_i.lo) : '0;

    ////////////////////////////////////////
    // result capture
    always_ff @(posedge clk_i) begin
        if (fin_valid_i) begin
            res_q <= fin_i;
            cnt_q <= cnt_nxt;
        end
    end

    ////////////////////////////////////////
    // sticky done, cleared by next start
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_q <= 1'b0;
        end else if (start_i) begin
            done_q <= 1'b0;
        end else if (fin_valid_i) begin
            done_q <= 1'b1;
        end
    end

    assign res_o  = res_q;
    assign cnt_o  = cnt_q;
    assign done_o = done_q;
    assign irq_o  = done_q;      // level irq, follows done

endmodule

/* src/wb_pkg.sv */
`include "fmi_settings.svh"

package wb_pkg;

    typedef logic [`WB_ADDR_W-1:0] wb_adr_t;

    // master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        wb_adr_t     adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    ////////////////////////////////////////
    // register map, byte offsets of 32-bit words
    localparam wb_adr_t REG_CTRL    = 8'h00;  // bit 0 start
    localparam wb_adr_t REG_STATUS  = 8'h04;  // bit 0 busy, bit 1 done
    localparam wb_adr_t REG_LEN     = 8'h08;
    localparam wb_adr_t REG_N       = 8'h0C;
    localparam wb_adr_t REG_C_A     = 8'h10;
    localparam wb_adr_t REG_C_C     = 8'h14;
    localparam wb_adr_t REG_C_G     = 8'h18;
    localparam wb_adr_t REG_C_T     = 8'h1C;
    localparam wb_adr_t REG_RES_LO  = 8'h20;
    localparam wb_adr_t REG_RES_HI  = 8'h24;
    localparam wb_adr_t REG_RES_CNT = 8'h28;
    localparam wb_adr_t REG_QRY     = 8'h80;  // word i = query symbol i

endpackage

/* src/wb_slave.sv */
`timescale 1ns/1ns

module wb_slave (
    input  logic               clk_i,
    input  logic               rst_i,
    input  wb_pkg::wb_req_t    wb_req_i,
    output wb_pkg::wb_rsp_t    wb_rsp_o,
    input  logic               busy_i,
    input  fmi_pkg::interval_t res_i,
    input  fmi_pkg::idx_t      cnt_i,
    input  logic               done_i,
    output logic               start_o,
    output fmi_pkg::ctab_t     ctab_o,
    output fmi_pkg::idx_t      n_o,
    output fmi_pkg::qlen_t     len_o,
    output logic               qry_we_o,
    output fmi_pkg::qaddr_t    qry_waddr_o,
    output fmi_pkg::sym_t      qry_wsym_o
);
    import wb_pkg::*;
    import fmi_pkg::*;

    logic        ack_q;
    logic        wr_en;      // write strobe in the ack cycle
    logic [31:0] rd_dat;
    ctab_t       ctab_q;
    idx_t        n_q;
    qlen_t       len_q;

    ////////////////////////////////////////
    // classic handshake, one ack per request
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_req_i.cyc && wb_req_i.stb && !ack_q;
        end
    end

    assign wr_en = ack_q && wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;

    // start only from idle
    assign start_o = wr_en && (wb_req_i.adr == REG_CTRL) && wb_req_i.dat[0] && !busy_i;

    // query slots sit above 0x80, word aligned
    assign qry_we_o    = wr_en && (wb_req_i.adr >= REG_QRY);
    assign qry_waddr_o = wb_req_i.adr[QRY_AW+1:2];
    assign qry_wsym_o  = wb_req_i.dat[1:0];

    ////////////////////////////////////////
    // config registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctab_q <= '0;
            n_q    <= '0;
            len_q  <= '0;
        end else if (wr_en) begin
            case (wb_req_i.adr)
                REG_LEN: begin
                    // longer than the buffer -> clamp
                    if (wb_req_i.dat > 32'(QRY_MAX))
                        len_q <= qlen_t'(QRY_MAX);
                    else
                        len_q <= qlen_t'(wb_req_i.dat);
                end
                REG_N:   n_q       <= idx_t'(wb_req_i.dat);
                REG_C_A: ctab_q[0] <= idx_t'(wb_req_i.dat);
                REG_C_C: ctab_q[1] <= idx_t'(wb_req_i.dat);
                REG_C_G: ctab_q[2] <= idx_t'(wb_req_i.dat);
                REG_C_T: ctab_q[3] <= idx_t'(wb_req_i.dat);
                default: ;                              // ctrl, results, query
            endcase
        end
    end

    assign ctab_o = ctab_q;
    assign n_o    = n_q;
    assign len_o  = len_q;

    ////////////////////////////////////////
    // read mux
    always_comb begin
        rd_dat = '0;
        case (wb_req_i.adr)
            REG_STATUS:  rd_dat = {30'd0, done_i, busy_i};
            REG_LEN:     rd_dat = 32'(len_q);
            REG_N:       rd_dat = 32'(n_q);
            REG_C_A:     rd_dat = 32'(ctab_q[0]);
            REG_C_C:     rd_dat = 32'(ctab_q[1]);
            REG_C_G:     rd_dat = 32'(ctab_q[2]);
            REG_C_T:     rd_dat = 32'(ctab_q[3]);
            REG_RES_LO:  rd_dat = 32'(res_i.lo);
            REG_RES_HI:  rd_dat = 32'(res_i.hi);
            REG_RES_CNT: rd_dat = 32'(cnt_i);
            default:     rd_dat = '0;                   // ctrl and query read as 0
        endcase
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = ack_q ? rd_dat : '0;           // quiet bus between acks

    // write decode uses the request in the ack cycle, so it must not move before then
    property p_req_held;
        @(posedge clk_i) disable iff (rst_i)
        wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack |=>
            wb_req_i.cyc && wb_req_i.stb && $stable(wb_req_i.adr)
            && $stable(wb_req_i.we) && $stable(wb_req_i.dat);
    endproperty
    a_req_held: assert property (p_req_held);

endmodule

/* test/tb_fm_accel.sv */
`timescale 1ns/1ns

module tb_fm_accel;
    import fmi_pkg::*;
    import wb_pkg::*;

    ////////////////////////////////////////
    // index under test, bwt of ACGTACGGTACA$
    localparam int                   BWT_LEN = 13;
    localparam logic [8*BWT_LEN-1:0] BWT     = "ACTT$AAACGCGG";

    localparam int NUM_Q       = 9;
    localparam int CYCLE_LIMIT = 200 * NUM_Q * 20;  // per query budget with wide margin

    typedef struct packed {
        logic [5:0]           len;
        logic [8*QRY_MAX-1:0] bases;              // ascii, base i in byte i
        idx_t                 hits;               // occurrences in the text
        logic                 poke;               // extra start while busy
    } stim_t;

    logic     clk    = 1'b0;
    logic     rst    = 1'b1;
    wb_req_t  wb_req = '0;
    wb_rsp_t  wb_rsp;
    logic     occ_req_valid;
    occ_req_t occ_req;
    logic     occ_rsp_valid;
    occ_rsp_t occ_rsp;
    logic     irq;
    int       cycles = 0;
    stim_t    stim [NUM_Q];

    always #5 clk = ~clk;

    fm_accel_top DUT (
        .clk_i           (clk),
        .rst_i           (rst),
        .wb_req_i        (wb_req),
        .wb_rsp_o        (wb_rsp),
        .occ_req_valid_o (occ_req_valid),
        .occ_req_o       (occ_req),
        .occ_rsp_valid_i (occ_rsp_valid),
        .occ_rsp_i       (occ_rsp),
        .irq_o           (irq)
    );

    tb_occ_mem #(.LEN(BWT_LEN), .BWT(BWT)) u_occ_mem (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_valid_i (occ_req_valid),
        .req_i       (occ_req),
        .rsp_valid_o (occ_rsp_valid),
        .rsp_o       (occ_rsp)
    );

    ////////////////////////////////////////
    // failure path and checks
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            report_fail($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            report_fail($sformatf("timeout: no finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    ////////////////////////////////////////
    // reference model from the bwt text
    function automatic logic [7:0] bwt_char(input int i);
        return BWT[8*(BWT_LEN-1-i) +: 8];
    endfunction

    function automatic int c_model(input logic [7:0] ch);
        int n;
        n = 0;
        for (int i = 0; i < BWT_LEN; i++) begin
            if (bwt_char(i) < ch) n++;            // '$' sorts below every base
        end
        return n;
    endfunction

    function automatic int occ_model(input logic [7:0] ch, input int pos);
        int n;
        n = 0;
        for (int i = 0; i < pos; i++) begin
            if (bwt_char(i) == ch) n++;
        end
        return n;
    endfunction

    function automatic logic [7:0] base_char(input int s);
        case (s)
            0:       return "A";
            1:       return "C";
            2:       return "G";
            default: return "T";
        endcase
    endfunction

    function automatic logic [1:0] base_code(input logic [7:0] ch);
        case (ch)
            "A":     return 2'd0;
            "C":     return 2'd1;
            "G":     return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    function automatic stim_t build_entry(input string q, input int hits, input logic poke);
        stim_t e;
        e      = '0;
        e.len  = 6'(q.len());
        e.hits = idx_t'(hits);
        e.poke = poke;
        for (int i = 0; i < q.len(); i++) begin
            e.bases[8*i +: 8] = q[i];
        end
        return e;
    endfunction

    ////////////////////////////////////////
    // wishbone master, sample at negedge
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        while (!wb_rsp.ack) @(negedge clk);
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;                             // write lands on this edge
    endtask

    task automatic write_reg(input wb_adr_t adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input wb_adr_t adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'd0, dat);
    endtask

    ////////////////////////////////////////
    // one table entry: load, start, wait, compare
    task automatic run_query(input stim_t e);
        logic [31:0] rd;
        logic [7:0]  ch;
        int          lo;
        int          hi;
        int          cnt;
        write_reg(REG_LEN, 32'(e.len));
        for (int i = 0; i < int'(e.len); i++) begin
            write_reg(wb_adr_t'(REG_QRY + 4*i), 32'(base_code(e.bases[8*i +: 8])));
        end
        write_reg(REG_CTRL, 32'h1);
        @(negedge clk);
        check_eq("irq_o after start", 32'(irq), 32'd0);   // old done cleared
        if (e.poke) begin
            read_reg(REG_STATUS, rd);
            check_eq("STATUS.busy", 32'(rd[0]), 32'd1);
            write_reg(REG_LEN, 32'd0);            // a restart would now return [0, N)
            write_reg(REG_CTRL, 32'h1);           // must not restart
        end
        rd = '0;
        while (!rd[1]) read_reg(REG_STATUS, rd);
        check_eq("STATUS.busy", 32'(rd[0]), 32'd0);
        @(negedge clk);
        check_eq("irq_o", 32'(irq), 32'd1);
        // backward search over the text, last base first
        lo = 0;
        hi = BWT_LEN;
        for (int i = int'(e.len) - 1; i >= 0; i--) begin
            if (lo < hi) begin
                ch = e.bases[8*i +: 8];
                lo = c_model(ch) + occ_model(ch, lo);
                hi = c_model(ch) + occ_model(ch, hi);
            end
        end
        cnt = (hi > lo) ? hi - lo : 0;
        read_reg(REG_RES_LO, rd);
        check_eq("RES_LO", rd, 32'(lo));
        read_reg(REG_RES_HI, rd);
        check_eq("RES_HI", rd, 32'(hi));
        read_reg(REG_RES_CNT, rd);
        check_eq("RES_CNT", rd, 32'(cnt));
        check_eq("RES_CNT vs occurrences", rd, 32'(e.hits));
    endtask

    ////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        stim[0] = build_entry("A",            4,  1'b0);
        stim[1] = build_entry("ACG",          2,  1'b0);
        stim[2] = build_entry("GTAC",         2,  1'b0);
        stim[3] = build_entry("TACA",         1,  1'b0);
        stim[4] = build_entry("ACGTACGGTACA", 1,  1'b1);  // whole text
        stim[5] = build_entry("CGG",          1,  1'b0);
        stim[6] = build_entry("TT",           0,  1'b0);
        stim[7] = build_entry("CCAGT",        0,  1'b1);  // empties midway
        stim[8] = build_entry("",             13, 1'b0);  // [0, N)

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // idle after reset
        @(negedge clk);
        check_eq("irq_o", 32'(irq), 32'd0);
        read_reg(REG_STATUS, rd);
        check_eq("STATUS", rd, 32'd0);

        // index config and readback
        for (int s = 0; s < 4; s++) begin
            write_reg(wb_adr_t'(REG_C_A + 4*s), 32'(c_model(base_char(s))));
        end
        write_reg(REG_N, 32'(BWT_LEN));
        write_reg(REG_LEN, 32'd12);
        for (int s = 0; s < 4; s++) begin
            read_reg(wb_adr_t'(REG_C_A + 4*s), rd);
            check_eq($sformatf("C[%0d]", s), rd, 32'(c_model(base_char(s))));
        end
        read_reg(REG_N, rd);
        check_eq("N", rd, 32'(BWT_LEN));
        read_reg(REG_LEN, rd);
        check_eq("LEN", rd, 32'd12);

        for (int k = 0; k < NUM_Q; k++) begin
            run_query(stim[k]);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* test/tb_occ_mem.sv */
`timescale 1ns/1ns

module tb_occ_mem #(
    parameter int               LEN = 13,
    parameter logic [8*LEN-1:0] BWT = '0          // ascii, bwt[0] in the top byte
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    input  fmi_pkg::occ_req_t req_i,
    output logic              rsp_valid_o,
    output fmi_pkg::occ_rsp_t rsp_o
);
    import fmi_pkg::*;

    logic [2:0]  bwt_q [LEN];                     // {sentinel, base}
    logic        pend_q      = 1'b0;              // request taken, delay running
    logic [2:0]  wait_q      = '0;
    occ_req_t    req_q       = '0;
    logic [31:0] rng_q       = 32'd93;
    logic [31:0] rng_nxt;
    logic        rsp_valid_q = 1'b0;
    occ_rsp_t    rsp_q       = '0;

    // xorshift32 step
    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // count of req.sym in bwt[0 .. pos-1], sentinel never matches
    function automatic idx_t occ_count(input occ_req_t r);
        int n;
        n = 0;
        for (int i = 0; i < LEN; i++) begin
            if (i < int'(r.pos) && bwt_q[i] == {1'b0, r.sym}) n++;
        end
        return idx_t'(n);
    endfunction

    ////////////////////////////////////////
    // text to base codes
    initial begin
        for (int i = 0; i < LEN; i++) begin
            case (BWT[8*(LEN-1-i) +: 8])
                "A":     bwt_q[i] = 3'b000;
                "C":     bwt_q[i] = 3'b001;
                "G":     bwt_q[i] = 3'b010;
                "T":     bwt_q[i] = 3'b011;
                default: bwt_q[i] = 3'b100;       // '$' marker
            endcase
        end
    end

    assign rng_nxt = next_rand(rng_q);

    ////////////////////////////////////////
    // one request at a time, 0..7 extra cycles
    always @(posedge clk_i) begin
        if (rst_i) begin
            pend_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
            wait_q      <= '0;
            rng_q       <= 32'd93;
        end else begin
            rsp_valid_q <= 1'b0;                  // single pulse
            if (rsp_valid_q) begin
                // master consumes the answer on this edge
            end else if (!pend_q && req_valid_i) begin
                pend_q <= 1'b1;
                req_q  <= req_i;
                rng_q  <= rng_nxt;
                wait_q <= rng_nxt[2:0];
            end else if (pend_q) begin
                if (wait_q == '0) begin
                    rsp_valid_q <= 1'b1;
                    rsp_q.cnt   <= occ_count(req_q);
                    pend_q      <= 1'b0;
                end else begin
                    wait_q <= wait_q - 1'b1;
                end
            end
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule
